// File: sim.f
+incdir+.
tmr_shift_pkg.sv
shift_lane.sv
majority_voter.sv
upset_monitor.sv
tmr_shift_reg.sv
tmr_shift_checker.sv
tb_tmr_shift.sv

// File: Makefile
TOP := tb_tmr_shift

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing +incdir+. tmr_shift_pkg.sv shift_lane.sv \
		majority_voter.sv upset_monitor.sv tmr_shift_reg.sv --top-module tmr_shift_reg
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o Vtb
	./obj_dir/Vtb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_tmr_shift.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_shift_cfg.svh"

module tb_tmr_shift
  import tmr_shift_pkg::*;
();

  localparam int W     = `TMR_WIDTH;
  localparam int IDX_W = `TMR_IDX_WIDTH;

  logic          clk = 1'b0;
  logic          rst;
  shift_ctrl_t   ctrl;
  logic [W-1:0]  parallel_in;
  inject_t       inject;
  logic          status_clear;
  logic [W-1:0]  parallel_out;
  logic          serial_out;
  upset_status_t status;
  logic          row_valid;
  logic [W-1:0]  row_word;
  int            err_count;
  int            check_count;
  int            row_seen;

  // Stimulus table, one entry per cycle
  string         name_q[$];
  shift_ctrl_t   ctrl_q[$];
  logic [W-1:0]  data_q[$];
  inject_t       inject_q[$];
  logic          clear_q[$];
  logic [W-1:0]  exp_q[$];
  logic [W-1:0]  model_w;  // Expected voted word while the table is built
  logic [31:0]   lcg_state;

  always #10 clk = ~clk;

  tmr_shift_reg i_dut (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .parallel_in (parallel_in),
    .inject      (inject),
    .status_clear(status_clear),
    .parallel_out(parallel_out),
    .serial_out  (serial_out),
    .status      (status)
  );

  tmr_shift_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .parallel_in (parallel_in),
    .inject      (inject),
    .status_clear(status_clear),
    .parallel_out(parallel_out),
    .serial_out  (serial_out),
    .status      (status),
    .row_valid   (row_valid),
    .row_word    (row_word),
    .err_count   (err_count),
    .check_count (check_count),
    .row_seen    (row_seen)
  );

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function logic [W-1:0] rand_word();
    return W'(lcg_next());
  endfunction

  function logic [IDX_W-1:0] rand_idx();
    logic [31:0] r;
    r = lcg_next();
    return IDX_W'(r % W);
  endfunction

  function automatic shift_ctrl_t make_ctrl(input logic en, input logic ld,
                                            input shift_mode_e mode, input logic sin);
    shift_ctrl_t c;
    c.enable    = en;
    c.load      = ld;
    c.mode      = mode;
    c.serial_in = sin;
    return c;
  endfunction

  task automatic add_row(input string name, input shift_ctrl_t c, input logic [W-1:0] data,
                         input logic [2:0] mask, input logic [IDX_W-1:0] idx,
                         input logic clear);
    inject_t inj;
    inj.lane_mask = mask;
    inj.bit_idx   = idx;
    name_q.push_back(name);
    ctrl_q.push_back(c);
    data_q.push_back(data);
    inject_q.push_back(inj);
    clear_q.push_back(clear);
    exp_q.push_back(model_w);
  endtask

  task automatic build_table();
    logic [W-1:0]     d;
    logic [IDX_W-1:0] b;
    logic [31:0]      r;
    shift_ctrl_t      hold;
    hold = make_ctrl(1'b0, 1'b0, PIPO, 1'b0);
    d = rand_word();
    model_w = d;
    add_row("pipo_load", make_ctrl(1'b1, 1'b1, PIPO, 1'b0), d, 3'b000, '0, 1'b0);
    add_row("pipo_hold_noload", make_ctrl(1'b1, 1'b0, PIPO, 1'b0), rand_word(), 3'b000, '0, 1'b0);
    add_row("pipo_hold_disabled", make_ctrl(1'b0, 1'b1, PIPO, 1'b0), rand_word(), 3'b000, '0,
            1'b0);
    for (int i = 0; i < 6; i++) begin
      r = lcg_next();
      model_w = {r[0], model_w[W-1:1]};  // Enters at the MSB
      add_row("siso_right", make_ctrl(1'b1, 1'b0, SISO_RIGHT, r[0]), rand_word(), 3'b000, '0, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      r = lcg_next();
      model_w = {model_w[W-2:0], r[0]};
      add_row("siso_left", make_ctrl(1'b1, 1'b0, SISO_LEFT, r[0]), rand_word(), 3'b000, '0, 1'b0);
    end
    d = rand_word();
    model_w = d;
    add_row("piso_load", make_ctrl(1'b1, 1'b1, PISO, 1'b0), d, 3'b000, '0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      model_w = {1'b0, model_w[W-1:1]};  // Zero fill even with serial_in high
      add_row("piso_shift", make_ctrl(1'b1, 1'b0, PISO, 1'b1), rand_word(), 3'b000, '0, 1'b0);
    end
    add_row("single_upset_a", hold, rand_word(), 3'b001, rand_idx(), 1'b0);
    add_row("single_upset_b", hold, rand_word(), 3'b010, rand_idx(), 1'b0);
    add_row("single_upset_idle", hold, rand_word(), 3'b000, '0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      r = lcg_next();
      model_w = {model_w[W-2:0], r[0]};
      add_row("upset_while_shift", make_ctrl(1'b1, 1'b0, SISO_LEFT, r[0]), rand_word(), 3'b100,
              rand_idx(), 1'b0);
    end
    b = rand_idx();
    model_w[b] = ~model_w[b];  // Two lanes now outvote the third
    add_row("double_upset", hold, rand_word(), 3'b011, b, 1'b0);
    add_row("double_upset_after", hold, rand_word(), 3'b000, '0, 1'b0);
    add_row("double_upset_after", hold, rand_word(), 3'b000, '0, 1'b0);
    add_row("clear_after_double", hold, rand_word(), 3'b000, '0, 1'b1);
    for (int i = 0; i < (1 << `TMR_CNT_WIDTH) + 20; i++) begin
      add_row("saturate_a", hold, rand_word(), 3'b001, rand_idx(), 1'b0);
    end
    add_row("clear_with_upset", hold, rand_word(), 3'b000, '0, 1'b1);
    add_row("after_clear", hold, rand_word(), 3'b000, '0, 1'b0);
    add_row("after_clear", hold, rand_word(), 3'b000, '0, 1'b0);
  endtask

  initial begin
    int   waited;
    logic run_ok;
    rst          = 1'b0;
    ctrl         = '0;
    parallel_in  = '0;
    inject       = '0;
    status_clear = 1'b0;
    row_valid    = 1'b0;
    row_word     = '0;
    lcg_state    = 32'hff9cdf0e;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    waited = 0;
    while (!(rst === 1'b1 && parallel_out === '0 && status === '0) && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    run_ok = (rst === 1'b1 && parallel_out === '0 && status === '0);
    if (!run_ok) begin
      $display("Timeout: DUT did not leave reset with cleared outputs");
    end else begin
      for (int k = 0; k < name_q.size(); k++) begin
        @(posedge clk);
        ctrl                  <= ctrl_q[k];
        parallel_in           <= data_q[k];
        inject                <= inject_q[k];
        status_clear          <= clear_q[k];
        row_valid             <= 1'b1;
        row_word              <= exp_q[k];
        i_checker.test_name   <= name_q[k];
      end
      @(posedge clk);
      ctrl                <= make_ctrl(1'b0, 1'b0, PIPO, 1'b0);
      inject              <= '0;
      status_clear        <= 1'b0;
      row_valid           <= 1'b0;
      i_checker.test_name <= "drain";
      waited = 0;
      while (row_seen < name_q.size() && waited < 20) begin
        @(negedge clk);
        waited++;
      end
      if (row_seen < name_q.size()) begin
        $display("Timeout: checker saw only %0d of %0d table rows", row_seen, name_q.size());
        run_ok = 1'b0;
      end
    end
    $display("Checks: %0d, table rows: %0d, errors: %0d", check_count, row_seen, err_count);
    if (run_ok && err_count == 0 && check_count > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tmr_shift_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_shift_cfg.svh"

module tmr_shift_checker
  import tmr_shift_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  shift_ctrl_t           ctrl,
  input  logic [`TMR_WIDTH-1:0] parallel_in,
  input  inject_t               inject,
  input  logic                  status_clear,
  input  logic [`TMR_WIDTH-1:0] parallel_out,
  input  logic                  serial_out,
  input  upset_status_t         status,
  input  logic                  row_valid,
  input  logic [`TMR_WIDTH-1:0] row_word,
  output int                    err_count,
  output int                    check_count,
  output int                    row_seen
);

  localparam int W = `TMR_WIDTH;

  string         test_name = "reset";  // Written by the testbench top
  string         name_seen;
  logic [W-1:0]  word_m;               // Expected voted word
  logic [2:0]    minority_m;           // Lanes outvoted in the current cycle
  upset_status_t status_m;
  logic          pend_valid;
  logic [W-1:0]  pend_word;
  logic [W-1:0]  step_w;
  logic          ser_exp;
  int            errs = 0;
  int            checks = 0;
  int            rows = 0;

  // Register step for one enabled cycle
  function automatic logic [W-1:0] next_word(input shift_ctrl_t c, input logic [W-1:0] pin,
                                             input logic [W-1:0] w);
    case (c.mode)
      SISO_RIGHT: return {c.serial_in, w[W-1:1]};
      SISO_LEFT:  return {w[W-2:0], c.serial_in};
      PISO:       return c.load ? pin : (w >> 1);
      default:    return c.load ? pin : w;
    endcase
  endfunction

  // Lanes left in the minority by one injection
  function automatic logic [2:0] outvoted(input logic [2:0] mask);
    case ($countones(mask))
      1:       return mask;
      2:       return ~mask;
      default: return 3'b000;
    endcase
  endfunction

  task automatic report_mismatch(input string what, input string exp_s, input string act_s);
    errs++;
    $display("ERR %s %s: expected %s actual %s at %0t", name_seen, what, exp_s, act_s, $time);
  endtask

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      word_m     <= '0;
      minority_m <= '0;
      status_m   <= '0;
      pend_valid <= 1'b0;
      pend_word  <= '0;
      name_seen  <= "reset";
    end else begin
      step_w = ctrl.enable ? next_word(ctrl, parallel_in, word_m) : word_m;
      if ($countones(inject.lane_mask) >= 2) begin
        step_w[inject.bit_idx] = ~step_w[inject.bit_idx];  // Flipped lanes win the vote
      end
      word_m     <= step_w;
      minority_m <= outvoted(inject.lane_mask);
      for (int i = 0; i < 3; i++) begin
        if (status_clear) begin
          status_m.count[i]  <= '0;
          status_m.sticky[i] <= 1'b0;
        end else if (minority_m[i]) begin
          status_m.sticky[i] <= 1'b1;
          if (status_m.count[i] != '1) begin
            status_m.count[i] <= status_m.count[i] + 1'b1;
          end
        end
      end
      pend_valid <= row_valid;
      pend_word  <= row_word;
      name_seen  <= test_name;
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst) begin
      // At most one lane is outvoted, so the serial bit follows the voted word
      ser_exp = (ctrl.mode == SISO_RIGHT || ctrl.mode == PISO) ? word_m[0] : word_m[W-1];
      checks++;
      if (parallel_out !== word_m) begin
        report_mismatch("parallel_out", $sformatf("%h", word_m), $sformatf("%h", parallel_out));
      end
      if (serial_out !== ser_exp) begin
        report_mismatch("serial_out", $sformatf("%b", ser_exp), $sformatf("%b", serial_out));
      end
      if (status !== status_m) begin
        report_mismatch("status", $sformatf("%h", status_m), $sformatf("%h", status));
      end
      if (pend_valid) begin
        rows++;
        if (parallel_out !== pend_word) begin
          report_mismatch("table word", $sformatf("%h", pend_word),
                          $sformatf("%h", parallel_out));
        end
      end
    end
  end

  assign err_count   = errs;
  assign check_count = checks;
  assign row_seen    = rows;

endmodule

`default_nettype wire

// File: tmr_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_shift_cfg.svh"

module tmr_shift_reg
  import tmr_shift_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  shift_ctrl_t           ctrl,
  input  logic [`TMR_WIDTH-1:0] parallel_in,
  input  inject_t               inject,
  input  logic                  status_clear,
  output logic [`TMR_WIDTH-1:0] parallel_out,
  output logic                  serial_out,
  output upset_status_t         status
);

  lane_out_t             lane_a;
  lane_out_t             lane_b;
  lane_out_t             lane_c;
  logic [`TMR_WIDTH-1:0] voted;
  logic [2:0]            mismatch;
  logic [2:0]            inject_hit;

  assign inject_hit = inject.lane_mask; // Bit i selects lane i

  shift_lane i_lane_a (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .parallel_in(parallel_in),
    .inject_hit (inject_hit[0]),
    .inject_bit (inject.bit_idx),
    .voted      (voted),
    .mismatch   (mismatch[0]),
    .lane       (lane_a)
  );

  shift_lane i_lane_b (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .parallel_in(parallel_in),
    .inject_hit (inject_hit[1]),
    .inject_bit (inject.bit_idx),
    .voted      (voted),
    .mismatch   (mismatch[1]),
    .lane       (lane_b)
  );

  shift_lane i_lane_c (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .parallel_in(parallel_in),
    .inject_hit (inject_hit[2]),
    .inject_bit (inject.bit_idx),
    .voted      (voted),
    .mismatch   (mismatch[2]),
    .lane       (lane_c)
  );

  majority_voter i_voter (
    .lane_a      (lane_a),
    .lane_b      (lane_b),
    .lane_c      (lane_c),
    .voted_word  (voted),
    .voted_serial(serial_out),
    .mismatch    (mismatch)
  );

  upset_monitor i_monitor (
    .clk         (clk),
    .rst         (rst),
    .mismatch    (mismatch),
    .status_clear(status_clear),
    .status      (status)
  );

  assign parallel_out = voted;

endmodule

`default_nettype wire

// File: upset_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_shift_cfg.svh"

module upset_monitor
  import tmr_shift_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic [2:0]    mismatch,
  input  logic          status_clear,
  output upset_status_t status
);

  logic [2:0][`TMR_CNT_WIDTH-1:0] cnt;
  logic [2:0]                     sticky;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt    <= '0;
      sticky <= '0;
    end else if (status_clear) begin
      // Clear beats a same-cycle upset
      cnt    <= '0;
      sticky <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (mismatch[i] && !(&cnt[i])) begin
          cnt[i] <= cnt[i] + 1'b1;  // Holds at all ones
        end
      end
      sticky <= sticky | mismatch;
    end
  end

  assign status.count  = cnt;
  assign status.sticky = sticky;

  for (genvar g = 0; g < 3; g++) begin : g_sat_chk
    a_no_wrap: assert property (
      @(posedge clk) disable iff (!rst)
      ((&cnt[g]) && !status_clear) |=> (cnt[g] != '0)
    ) else $error("upset_monitor: counter %0d wrapped", g);
  end

endmodule

`default_nettype wire

// File: majority_voter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_shift_cfg.svh"

module majority_voter
  import tmr_shift_pkg::*;
(
  input  lane_out_t             lane_a,
  input  lane_out_t             lane_b,
  input  lane_out_t             lane_c,
  output logic [`TMR_WIDTH-1:0] voted_word,
  output logic                  voted_serial,
  output logic [2:0]            mismatch
);

  // Two-of-three vote per bit
  function automatic logic [`TMR_WIDTH-1:0] vote3(
    input logic [`TMR_WIDTH-1:0] a,
    input logic [`TMR_WIDTH-1:0] b,
    input logic [`TMR_WIDTH-1:0] c
  );
    return (a & b) | (a & c) | (b & c);
  endfunction

  always_comb begin
    voted_word   = vote3(lane_a.word, lane_b.word, lane_c.word);
    voted_serial = (lane_a.serial & lane_b.serial) |
                   (lane_a.serial & lane_c.serial) |
                   (lane_b.serial & lane_c.serial);

    mismatch[0] = (lane_a.word != voted_word);
    mismatch[1] = (lane_b.word != voted_word);
    mismatch[2] = (lane_c.word != voted_word);

    // Two lanes in the minority must also disagree with each other
    if (mismatch[0] && mismatch[1]) begin
      a_pair_ab: assert (lane_a.word != lane_b.word)
        else $error("majority_voter: lanes a and b agree but both outvoted");
    end
    if (mismatch[0] && mismatch[2]) begin
      a_pair_ac: assert (lane_a.word != lane_c.word)
        else $error("majority_voter: lanes a and c agree but both outvoted");
    end
    if (mismatch[1] && mismatch[2]) begin
      a_pair_bc: assert (lane_b.word != lane_c.word)
        else $error("majority_voter: lanes b and c agree but both outvoted");
    end
  end

endmodule

`default_nettype wire

// File: shift_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "tmr_shift_cfg.svh"

module shift_lane
  import tmr_shift_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  shift_ctrl_t               ctrl,
  input  logic [`TMR_WIDTH-1:0]     parallel_in,
  input  logic                      inject_hit,
  input  logic [`TMR_IDX_WIDTH-1:0] inject_bit,
  input  logic [`TMR_WIDTH-1:0]     voted,
  input  logic                      mismatch,
  output lane_out_t                 lane
);

  logic [`TMR_WIDTH-1:0] word_q;
  logic [`TMR_WIDTH-1:0] base;
  logic [`TMR_WIDTH-1:0] shifted;
  logic [`TMR_WIDTH-1:0] stepped;
  logic [`TMR_WIDTH-1:0] flip;
  logic [`TMR_WIDTH-1:0] word_d;
  logic                  update;

  // Scrub from the vote when this lane is outvoted
  assign base = mismatch ? voted : word_q;

  always_comb begin
    case (ctrl.mode)
      SISO_RIGHT: shifted = {ctrl.serial_in, base[`TMR_WIDTH-1:1]};
      SISO_LEFT:  shifted = {base[`TMR_WIDTH-2:0], ctrl.serial_in};
      PISO:       shifted = ctrl.load ? parallel_in : {1'b0, base[`TMR_WIDTH-1:1]};
      PIPO:       shifted = ctrl.load ? parallel_in : base;
      default:    shifted = base;
    endcase
  end

  assign stepped = ctrl.enable ? shifted : base;

  // One-hot flip of the chosen bit
  assign flip = inject_hit ? ({{(`TMR_WIDTH-1){1'b0}}, 1'b1} << inject_bit) : '0;

  assign word_d = stepped ^ flip;
  assign update = mismatch | ctrl.enable | inject_hit;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      word_q <= '0;
    end else if (update) begin
      word_q <= word_d;
    end
  end

  assign lane.word = word_q;
  // LSB first for right shifts, MSB first otherwise
  assign lane.serial = (ctrl.mode == SISO_RIGHT || ctrl.mode == PISO) ?
                       word_q[0] : word_q[`TMR_WIDTH-1];

  // An outvoted lane rejoins the vote within one edge
  a_scrub: assert property (
    @(posedge clk) disable iff (!rst)
    (mismatch && !inject_hit) |=> (word_q == $past(voted) || word_q == $past(shifted))
  ) else $error("shift_lane: scrub did not restore voted word");

endmodule

`default_nettype wire

// File: tmr_shift_pkg.sv
`default_nettype none

`include "tmr_shift_cfg.svh"

package tmr_shift_pkg;

  // Two-bit mode field encodings
  typedef enum logic [1:0] {
    SISO_RIGHT = 2'b00,
    SISO_LEFT  = 2'b01,
    PISO       = 2'b10,
    PIPO       = 2'b11
  } shift_mode_e;

  typedef struct packed {
    logic        enable;
    logic        load;
    shift_mode_e mode;
    logic        serial_in;
  } shift_ctrl_t;

  // Fault injection request
  typedef struct packed {
    logic [2:0]                  lane_mask; // Bit 0 is lane a
    logic [`TMR_IDX_WIDTH-1:0]   bit_idx;
  } inject_t;

  typedef struct packed {
    logic [`TMR_WIDTH-1:0] word;
    logic                  serial;
  } lane_out_t;

  // Index 0 is lane a, 2 is lane c
  typedef struct packed {
    logic [2:0][`TMR_CNT_WIDTH-1:0] count;
    logic [2:0]                     sticky;
  } upset_status_t;

endpackage

`default_nettype wire

// File: tmr_shift_cfg.svh
`ifndef TMR_SHIFT_CFG_SVH
`define TMR_SHIFT_CFG_SVH

// Lane word width of 2 or more bits
`define TMR_WIDTH 32

// Width of each per-lane upset counter
`define TMR_CNT_WIDTH 8

// Bits needed to address one bit of the word
`define TMR_IDX_WIDTH $clog2(`TMR_WIDTH)

`endif
